// ==== sources.f ====
source/poller_pkg.sv
source/poller_ifs.sv
source/msg_req_queue.sv
source/msg_req_table.sv
source/ptr_table.sv
source/poller_ctrl.sv
source/poller_datapath.sv
source/msg_ptr_poller.sv
verif/poller_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the poller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module poller_tb -f sources.f -o poller_sim

out=$(./obj_dir/poller_sim)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "RESULT: PASS"

// ==== verif/poller_tb.sv ====
`timescale 1ns/10ps

module poller_tb;
    import poller_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int HALF_PERIOD = 5;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     app_req_val = 1'b0;
    flowid_t  app_req_flowid = '0;
    msg_len_t app_req_len = '0;
    logic     app_req_rdy;
    logic     base_wr_val = 1'b0;
    flowid_t  base_wr_flowid = '0;
    ptr_t     base_wr_ptr = '0;
    logic     end_wr_val = 1'b0;
    flowid_t  end_wr_flowid = '0;
    ptr_t     end_wr_ptr = '0;
    logic     notif_val;
    logic     notif_rdy = 1'b0;
    flowid_t  notif_flowid;
    ptr_t     notif_ptr;
    msg_len_t notif_len;

    // reference model built from the testbench's own writes
    ptr_t                model_base [FLOW_CNT];
    ptr_t                model_end  [FLOW_CNT];
    msg_len_t            model_len  [FLOW_CNT];
    logic [FLOW_CNT-1:0] model_active;

    logic     exp_active;
    msg_len_t exp_len;
    ptr_t     exp_ptr;
    ptr_t     exp_avail;

    string test_name = "reset";
    int    err_cnt = 0;
    int    err_mark = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    logic  want_rdy = 1'b0;
    logic  want_busy = 1'b0;
    logic  want_idle = 1'b0;
    logic  rdy_random = 1'b0;

    msg_ptr_poller DUT (
         .clk            (clk)
        ,.rst            (rst)
        ,.app_req_val    (app_req_val)
        ,.app_req_flowid (app_req_flowid)
        ,.app_req_len    (app_req_len)
        ,.app_req_rdy    (app_req_rdy)
        ,.base_wr_val    (base_wr_val)
        ,.base_wr_flowid (base_wr_flowid)
        ,.base_wr_ptr    (base_wr_ptr)
        ,.end_wr_val     (end_wr_val)
        ,.end_wr_flowid  (end_wr_flowid)
        ,.end_wr_ptr     (end_wr_ptr)
        ,.notif_val      (notif_val)
        ,.notif_rdy      (notif_rdy)
        ,.notif_flowid   (notif_flowid)
        ,.notif_ptr      (notif_ptr)
        ,.notif_len      (notif_len)
    );

    always #HALF_PERIOD clk = ~clk;

    // destination ready one cycle in four once randomized
    always @(negedge clk) begin
        if (rdy_random) begin
            notif_rdy = ($urandom_range(3) == 0);
        end
        else begin
            notif_rdy = 1'b1;
        end
    end

    // a request is taken only when its flow has nothing pending
    always @(posedge clk) begin
        if (rst) begin
            model_active <= '0;
        end
        else begin
            if (notif_val && notif_rdy) begin
                model_active[notif_flowid] <= 1'b0;
            end
            if (app_req_val && !model_active[app_req_flowid]) begin
                model_active[app_req_flowid] <= 1'b1;
                model_len[app_req_flowid] <= app_req_len;
            end
        end
    end

    assign exp_active = model_active[notif_flowid];
    assign exp_len = model_len[notif_flowid];
    assign exp_ptr = model_base[notif_flowid];
    assign exp_avail = model_end[notif_flowid] - model_base[notif_flowid];

    ////////////////////
    // checks
    ////////////////////
    a_rdy: assert property (@(posedge clk) disable iff (rst) want_rdy |-> app_req_rdy)
        else begin
            err_cnt++;
            $display("ERROR %s: app_req_rdy flow %0d expected 1 actual %0d",
                test_name, $sampled(app_req_flowid), $sampled(app_req_rdy));
        end

    a_busy: assert property (@(posedge clk) disable iff (rst) want_busy |-> !app_req_rdy)
        else begin
            err_cnt++;
            $display("ERROR %s: app_req_rdy flow %0d expected 0 actual %0d",
                test_name, $sampled(app_req_flowid), $sampled(app_req_rdy));
        end

    a_idle: assert property (@(posedge clk) disable iff (rst) want_idle |-> !notif_val)
        else begin
            err_cnt++;
            $display("ERROR %s: notif_val expected 0 actual 1", test_name);
        end

    a_notif_active: assert property (@(posedge clk) disable iff (rst)
        notif_val |-> exp_active)
        else begin
            err_cnt++;
            $display("ERROR %s: notification for flow %0d which has no pending request",
                test_name, $sampled(notif_flowid));
        end

    a_notif_len: assert property (@(posedge clk) disable iff (rst)
        notif_val |-> notif_len == exp_len)
        else begin
            err_cnt++;
            $display("ERROR %s: notif_len flow %0d expected %0d actual %0d", test_name,
                $sampled(notif_flowid), $sampled(exp_len), $sampled(notif_len));
        end

    a_notif_ptr: assert property (@(posedge clk) disable iff (rst)
        notif_val |-> notif_ptr == exp_ptr)
        else begin
            err_cnt++;
            $display("ERROR %s: notif_ptr flow %0d expected %0h actual %0h", test_name,
                $sampled(notif_flowid), $sampled(exp_ptr), $sampled(notif_ptr));
        end

    a_notif_rule: assert property (@(posedge clk) disable iff (rst)
        notif_val |-> exp_avail >= notif_len)
        else begin
            err_cnt++;
            $display("ERROR %s: flow %0d notified early, expected at least %0d bytes actual %0d",
                test_name, $sampled(notif_flowid), $sampled(notif_len), $sampled(exp_avail));
        end

    a_notif_hold: assert property (@(posedge clk) disable iff (rst)
        notif_val && !notif_rdy |=> notif_val && $stable(notif_flowid)
            && $stable(notif_ptr) && $stable(notif_len))
        else begin
            err_cnt++;
            $display("ERROR %s: notification dropped or changed before notif_rdy", test_name);
        end

    ////////////////////
    // drivers
    ////////////////////
    task automatic write_ptrs(input flowid_t f, input ptr_t base, input ptr_t end_p);
        base_wr_val = 1'b1;
        base_wr_flowid = f;
        base_wr_ptr = base;
        end_wr_val = 1'b1;
        end_wr_flowid = f;
        end_wr_ptr = end_p;
        model_base[f] = base;
        model_end[f] = end_p;
        @(negedge clk);
        base_wr_val = 1'b0;
        end_wr_val = 1'b0;
    endtask

    task automatic write_end(input flowid_t f, input ptr_t end_p);
        end_wr_val = 1'b1;
        end_wr_flowid = f;
        end_wr_ptr = end_p;
        model_end[f] = end_p;
        @(negedge clk);
        end_wr_val = 1'b0;
    endtask

    task automatic post_request(input flowid_t f, input msg_len_t len);
        app_req_val = 1'b1;
        app_req_flowid = f;
        app_req_len = len;
        @(negedge clk);
        app_req_val = 1'b0;
    endtask

    task automatic wait_drained();
        while (model_active != '0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", test_name);
        end
        else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, err_cnt - err_mark);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////
    initial begin
        flowid_t f;
        flowid_t g;
        flowid_t h;
        ptr_t    p;

        void'($urandom(32'h8676));
        for (int i = 0; i < FLOW_CNT; i++) begin
            model_base[i] = '0;
            model_end[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        want_idle = 1'b1;
        want_rdy = 1'b1;
        f = '0;
        repeat (FLOW_CNT) begin
            app_req_flowid = f;
            @(negedge clk);
            f = f + 1'b1;
        end
        want_rdy = 1'b0;
        want_idle = 1'b0;
        finish_test();

        start_test("satisfied");
        write_ptrs(3'd1, 16'd200, 16'd300);
        post_request(3'd1, 16'd64);
        wait_drained();
        // flow is free again
        want_rdy = 1'b1;
        app_req_flowid = 3'd1;
        @(negedge clk);
        want_rdy = 1'b0;
        finish_test();

        start_test("unsatisfied");
        write_ptrs(3'd2, 16'd1000, 16'd1010);
        post_request(3'd2, 16'd40);
        repeat (100) @(negedge clk);
        write_end(3'd2, 16'd1030);
        repeat (50) @(negedge clk);
        write_end(3'd2, 16'd1040);
        wait_drained();
        finish_test();

        start_test("busy_flow");
        write_ptrs(3'd5, 16'd50, 16'd60);
        post_request(3'd5, 16'd30);
        want_busy = 1'b1;
        post_request(3'd5, 16'd99);
        want_busy = 1'b0;
        write_end(3'd5, 16'd80);
        wait_drained();
        finish_test();

        start_test("backpressure");
        rdy_random = 1'b1;
        write_ptrs(3'd6, 16'd10, 16'd90);
        write_ptrs(3'd7, 16'd500, 16'd520);
        write_ptrs(3'd0, 16'hfff0, 16'h0010);
        post_request(3'd6, 16'd80);
        post_request(3'd7, 16'd5);
        post_request(3'd0, 16'd32);
        wait_drained();
        finish_test();

        start_test("random_mix");
        // start near the top so pointers wrap
        f = '0;
        repeat (FLOW_CNT) begin
            p = 16'hffc0 + ptr_t'($urandom_range(63));
            write_ptrs(f, p, p + ptr_t'($urandom_range(40)));
            f = f + 1'b1;
        end
        for (int i = 0; i < 400; i++) begin
            f = flowid_t'($urandom_range(FLOW_CNT - 1));
            g = flowid_t'($urandom_range(FLOW_CNT - 1));
            h = flowid_t'($urandom_range(FLOW_CNT - 1));
            if (!model_active[f] && $urandom_range(3) == 0) begin
                app_req_val = 1'b1;
                app_req_flowid = f;
                app_req_len = msg_len_t'($urandom_range(200, 1));
            end
            if ($urandom_range(1) == 0 && ptr_t'(model_end[g] - model_base[g]) < 16'd1000) begin
                p = model_end[g] + ptr_t'($urandom_range(60));
                end_wr_val = 1'b1;
                end_wr_flowid = g;
                end_wr_ptr = p;
                model_end[g] = p;
            end
            // base moves only while the flow has no pending request
            if (!model_active[h] && $urandom_range(7) == 0) begin
                p = model_end[h] - ptr_t'($urandom_range(20));
                base_wr_val = 1'b1;
                base_wr_flowid = h;
                base_wr_ptr = p;
                model_base[h] = p;
            end
            @(negedge clk);
            app_req_val = 1'b0;
            end_wr_val = 1'b0;
            base_wr_val = 1'b0;
        end
        f = '0;
        repeat (FLOW_CNT) begin
            if (model_active[f] && ptr_t'(model_end[f] - model_base[f]) < model_len[f]) begin
                write_end(f, model_base[f] + model_len[f]);
            end
            f = f + 1'b1;
        end
        wait_drained();
        finish_test();

        repeat (10) @(negedge clk);
        $display("tests passed %0d, failed %0d, assertion errors %0d",
            pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired: the tests did not finish within %0d cycles",
            NUM_TESTS * 2000);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== source/msg_ptr_poller.sv ====
`timescale 1ns/10ps

module msg_ptr_poller (
     input  logic                 clk
    ,input  logic                 rst

    ,input  logic                 app_req_val
    ,input  poller_pkg::flowid_t  app_req_flowid
    ,input  poller_pkg::msg_len_t app_req_len
    ,output logic                 app_req_rdy

    ,input  logic                 base_wr_val
    ,input  poller_pkg::flowid_t  base_wr_flowid
    ,input  poller_pkg::ptr_t     base_wr_ptr

    ,input  logic                 end_wr_val
    ,input  poller_pkg::flowid_t  end_wr_flowid
    ,input  poller_pkg::ptr_t     end_wr_ptr

    ,output logic                 notif_val
    ,input  logic                 notif_rdy
    ,output poller_pkg::flowid_t  notif_flowid
    ,output poller_pkg::ptr_t     notif_ptr
    ,output poller_pkg::msg_len_t notif_len
);
    import poller_pkg::*;

    logic    enq_val;
    flowid_t enq_flowid;
    logic    requeue_val;
    logic    requeue_rdy;
    logic    q_rd;
    logic    q_empty;
    flowid_t q_head;
    logic    clear_val;

    tbl_rd_if #(.data_t(msg_len_t)) req_if ();
    tbl_rd_if #(.data_t(ptr_t))     base_if ();
    tbl_rd_if #(.data_t(ptr_t))     end_if ();
    poll_dp_if                      dp_if ();

    // every table is read for the flow the datapath holds
    assign req_if.rd_req_addr = dp_if.held_flowid;
    assign base_if.rd_req_addr = dp_if.held_flowid;
    assign end_if.rd_req_addr = dp_if.held_flowid;

    msg_req_queue u_queue (
         .clk            (clk)
        ,.rst            (rst)
        ,.new_val        (enq_val)
        ,.new_flowid     (enq_flowid)
        ,.requeue_val    (requeue_val)
        ,.requeue_flowid (dp_if.held_flowid)
        ,.requeue_rdy    (requeue_rdy)
        ,.rd             (q_rd)
        ,.head           (q_head)
        ,.empty          (q_empty)
    );

    msg_req_table u_req_table (
         .clk            (clk)
        ,.rst            (rst)
        ,.app_req_val    (app_req_val)
        ,.app_req_flowid (app_req_flowid)
        ,.app_req_len    (app_req_len)
        ,.app_req_rdy    (app_req_rdy)
        ,.enq_val        (enq_val)
        ,.enq_flowid     (enq_flowid)
        ,.clear_val      (clear_val)
        ,.clear_flowid   (dp_if.held_flowid)
        ,.rd             (req_if.tbl)
    );

    ptr_table u_base_table (
         .clk       (clk)
        ,.rst       (rst)
        ,.wr_val    (base_wr_val)
        ,.wr_flowid (base_wr_flowid)
        ,.wr_ptr    (base_wr_ptr)
        ,.rd        (base_if.tbl)
    );

    ptr_table u_end_table (
         .clk       (clk)
        ,.rst       (rst)
        ,.wr_val    (end_wr_val)
        ,.wr_flowid (end_wr_flowid)
        ,.wr_ptr    (end_wr_ptr)
        ,.rd        (end_if.tbl)
    );

    poller_ctrl u_ctrl (
         .clk         (clk)
        ,.rst         (rst)
        ,.empty       (q_empty)
        ,.q_rd        (q_rd)
        ,.requeue_val (requeue_val)
        ,.requeue_rdy (requeue_rdy)
        ,.req_rd      (req_if.reader)
        ,.base_rd     (base_if.reader)
        ,.end_rd      (end_if.reader)
        ,.notif_val   (notif_val)
        ,.notif_rdy   (notif_rdy)
        ,.clear_val   (clear_val)
        ,.dp          (dp_if.ctrl)
    );

    poller_datapath u_datapath (
         .clk          (clk)
        ,.head         (q_head)
        ,.req_resp     (req_if.rd_resp_data)
        ,.base_resp    (base_if.rd_resp_data)
        ,.end_resp     (end_if.rd_resp_data)
        ,.dp           (dp_if.datapath)
        ,.notif_flowid (notif_flowid)
        ,.notif_ptr    (notif_ptr)
        ,.notif_len    (notif_len)
    );

endmodule

// ==== source/poller_datapath.sv ====
`timescale 1ns/10ps

module poller_datapath (
     input  logic                 clk

    ,input  poller_pkg::flowid_t  head
    ,input  poller_pkg::msg_len_t req_resp
    ,input  poller_pkg::ptr_t     base_resp
    ,input  poller_pkg::ptr_t     end_resp

    ,poll_dp_if.datapath          dp

    ,output poller_pkg::flowid_t  notif_flowid
    ,output poller_pkg::ptr_t     notif_ptr
    ,output poller_pkg::msg_len_t notif_len
);
    import poller_pkg::*;

    flowid_t  flowid_reg;
    msg_len_t len_reg;
    ptr_t     base_reg;
    ptr_t     end_reg;
    ptr_t     avail;

    always_ff @(posedge clk) begin
        if (dp.store_flowid) begin
            flowid_reg <= head;
        end
        if (dp.store_req_data) begin
            len_reg <= req_resp;
        end
        if (dp.store_ptrs) begin
            base_reg <= base_resp;
            end_reg <= end_resp;
        end
    end

    // head addresses the length read while it is being popped
    assign dp.held_flowid = dp.store_flowid ? head : flowid_reg;

    // pointers wrap, so the byte count is the modular difference
    assign avail = end_reg - base_reg;
    assign dp.satis = (avail >= len_reg);

    assign notif_flowid = flowid_reg;
    assign notif_ptr = base_reg;
    assign notif_len = len_reg;

endmodule

// ==== source/poller_ctrl.sv ====
`timescale 1ns/10ps

module poller_ctrl (
     input  logic       clk
    ,input  logic       rst

    ,input  logic       empty
    ,output logic       q_rd

    ,output logic       requeue_val
    ,input  logic       requeue_rdy

    ,tbl_rd_if.reader   req_rd
    ,tbl_rd_if.reader   base_rd
    ,tbl_rd_if.reader   end_rd

    ,output logic       notif_val
    ,input  logic       notif_rdy

    ,output logic       clear_val

    ,poll_dp_if.ctrl    dp
);
    import poller_pkg::*;

    poller_state_e state_reg;
    poller_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        q_rd = 1'b0;
        requeue_val = 1'b0;
        notif_val = 1'b0;
        clear_val = 1'b0;

        req_rd.rd_req_val = 1'b0;
        base_rd.rd_req_val = 1'b0;
        end_rd.rd_req_val = 1'b0;
        req_rd.rd_resp_rdy = 1'b0;
        base_rd.rd_resp_rdy = 1'b0;
        end_rd.rd_resp_rdy = 1'b0;

        dp.store_flowid = 1'b0;
        dp.store_req_data = 1'b0;
        dp.store_ptrs = 1'b0;

        state_next = state_reg;
        case (state_reg)
            READY: begin
                // pop the head and fetch its length in one go
                if (~empty & req_rd.rd_req_rdy) begin
                    dp.store_flowid = 1'b1;
                    q_rd = 1'b1;
                    req_rd.rd_req_val = 1'b1;
                    state_next = RD_PTRS;
                end
            end
            RD_PTRS: begin
                if (base_rd.rd_req_rdy & end_rd.rd_req_rdy) begin
                    base_rd.rd_req_val = 1'b1;
                    end_rd.rd_req_val = 1'b1;
                    state_next = STATE_RESP;
                end
            end
            STATE_RESP: begin
                dp.store_req_data = 1'b1;
                dp.store_ptrs = 1'b1;
                if (base_rd.rd_resp_val & end_rd.rd_resp_val & req_rd.rd_resp_val) begin
                    req_rd.rd_resp_rdy = 1'b1;
                    base_rd.rd_resp_rdy = 1'b1;
                    end_rd.rd_resp_rdy = 1'b1;
                    state_next = CALC;
                end
            end
            CALC: begin
                state_next = dp.satis ? SEND_NOTIF : REQUEUE_FLOW;
            end
            REQUEUE_FLOW: begin
                requeue_val = 1'b1;
                if (requeue_rdy) begin
                    state_next = READY;
                end
            end
            SEND_NOTIF: begin
                notif_val = 1'b1;
                if (notif_rdy) begin
                    clear_val = 1'b1;
                    state_next = READY;
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

    // notification stays up with the same flow until the destination takes it
    a_notif_hold: assert property (@(posedge clk) disable iff (rst)
        notif_val && !notif_rdy |=> notif_val && $stable(dp.held_flowid));

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state_reg inside {READY, RD_PTRS, STATE_RESP, CALC, REQUEUE_FLOW, SEND_NOTIF});

endmodule

// ==== source/ptr_table.sv ====
`timescale 1ns/10ps

module ptr_table (
     input  logic                clk
    ,input  logic                rst

    ,input  logic                wr_val
    ,input  poller_pkg::flowid_t wr_flowid
    ,input  poller_pkg::ptr_t    wr_ptr

    ,tbl_rd_if.tbl               rd
);
    import poller_pkg::*;

    ptr_t ptrs [FLOW_CNT];
    logic resp_val;
    ptr_t resp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptrs <= '{default: '0};
        end
        else if (wr_val) begin
            ptrs[wr_flowid] <= wr_ptr;
        end
    end

    // response held until the reader takes it
    assign rd.rd_req_rdy = ~resp_val;
    assign rd.rd_resp_val = resp_val;
    assign rd.rd_resp_data = resp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_val <= 1'b0;
        end
        else if (rd.rd_req_val & ~resp_val) begin
            resp_val <= 1'b1;
        end
        else if (rd.rd_resp_rdy) begin
            resp_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rd_req_val & ~resp_val) begin
            resp_data <= ptrs[rd.rd_req_addr];
        end
    end

endmodule

// ==== source/msg_req_table.sv ====
`timescale 1ns/10ps

module msg_req_table (
     input  logic                 clk
    ,input  logic                 rst

    ,input  logic                 app_req_val
    ,input  poller_pkg::flowid_t  app_req_flowid
    ,input  poller_pkg::msg_len_t app_req_len
    ,output logic                 app_req_rdy

    ,output logic                 enq_val
    ,output poller_pkg::flowid_t  enq_flowid

    ,input  logic                 clear_val
    ,input  poller_pkg::flowid_t  clear_flowid

    ,tbl_rd_if.tbl                rd
);
    import poller_pkg::*;

    msg_len_t            len_mem [FLOW_CNT];
    logic [FLOW_CNT-1:0] active;
    logic                accept;
    logic                resp_val;
    msg_len_t            resp_data;

    // one outstanding request per flow
    assign app_req_rdy = ~active[app_req_flowid];
    assign accept = app_req_val & app_req_rdy;

    assign enq_val = accept;
    assign enq_flowid = app_req_flowid;

    always_ff @(posedge clk) begin
        if (accept) begin
            len_mem[app_req_flowid] <= app_req_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= '0;
        end
        else begin
            if (clear_val) begin
                active[clear_flowid] <= 1'b0;
            end
            if (accept) begin
                active[app_req_flowid] <= 1'b1;
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////
    assign rd.rd_req_rdy = ~resp_val;
    assign rd.rd_resp_val = resp_val;
    assign rd.rd_resp_data = resp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_val <= 1'b0;
        end
        else if (rd.rd_req_val & ~resp_val) begin
            resp_val <= 1'b1;
        end
        else if (rd.rd_resp_rdy) begin
            resp_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rd_req_val & ~resp_val) begin
            resp_data <= len_mem[rd.rd_req_addr];
        end
    end

    // the poller only retires flows it actually holds
    a_clear_active: assert property (@(posedge clk) disable iff (rst)
        clear_val |-> active[clear_flowid]);

endmodule

// ==== source/msg_req_queue.sv ====
`timescale 1ns/10ps

module msg_req_queue (
     input  logic                clk
    ,input  logic                rst

    ,input  logic                new_val
    ,input  poller_pkg::flowid_t new_flowid

    ,input  logic                requeue_val
    ,input  poller_pkg::flowid_t requeue_flowid
    ,output logic                requeue_rdy

    ,input  logic                rd
    ,output poller_pkg::flowid_t head
    ,output logic                empty
);
    import poller_pkg::*;

    flowid_t             mem [FLOW_CNT];
    logic [FLOWID_W-1:0] rd_ptr;
    logic [FLOWID_W-1:0] wr_ptr;
    logic [QCNT_W-1:0]   count;
    logic                wr_en;
    flowid_t             wr_data;

    // new requests win the single write port
    assign requeue_rdy = ~new_val;
    assign wr_en = new_val | requeue_val;
    assign wr_data = new_val ? new_flowid : requeue_flowid;

    assign head = mem[rd_ptr];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a flow sits here at most once while active, so depth FLOW_CNT is enough
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en && !rd |-> count < QCNT_W'(FLOW_CNT));

endmodule

// ==== source/poller_ifs.sv ====
`timescale 1ns/10ps

// read path into one per-flow table
interface tbl_rd_if #(parameter type data_t = poller_pkg::ptr_t) ();
    import poller_pkg::*;

    logic    rd_req_val;
    flowid_t rd_req_addr;
    logic    rd_req_rdy;
    logic    rd_resp_val;
    data_t   rd_resp_data;
    logic    rd_resp_rdy;

    modport reader (
         output rd_req_val
        ,output rd_req_addr
        ,input  rd_req_rdy
        ,input  rd_resp_val
        ,input  rd_resp_data
        ,output rd_resp_rdy
    );

    modport tbl (
         input  rd_req_val
        ,input  rd_req_addr
        ,output rd_req_rdy
        ,output rd_resp_val
        ,output rd_resp_data
        ,input  rd_resp_rdy
    );
endinterface

// control strobes into the datapath and its status back
interface poll_dp_if ();
    import poller_pkg::*;

    logic    store_flowid;
    logic    store_req_data;
    logic    store_ptrs;
    logic    satis;
    flowid_t held_flowid;

    modport ctrl (
         output store_flowid
        ,output store_req_data
        ,output store_ptrs
        ,input  satis
        ,input  held_flowid
    );

    modport datapath (
         input  store_flowid
        ,input  store_req_data
        ,input  store_ptrs
        ,output satis
        ,output held_flowid
    );
endinterface

// ==== source/poller_pkg.sv ====
package poller_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int FLOW_CNT = 8;
    localparam int FLOWID_W = 3;
    localparam int PTR_W    = 16;
    localparam int LEN_W    = 16;

    // queue occupancy has to reach FLOW_CNT itself
    localparam int QCNT_W   = FLOWID_W + 1;

    ////////////////////
    // types
    ////////////////////
    typedef logic [FLOWID_W-1:0] flowid_t;
    typedef logic [PTR_W-1:0]    ptr_t;
    typedef logic [LEN_W-1:0]    msg_len_t;

    typedef enum logic [2:0] {
        READY        = 3'd0,
        RD_PTRS      = 3'd1,
        STATE_RESP   = 3'd2,
        CALC         = 3'd3,
        REQUEUE_FLOW = 3'd4,
        SEND_NOTIF   = 3'd5
    } poller_state_e;

endpackage
